// ==== design/baudTickGen.sv ====
// baud tick generator producing the 16x oversampling strobe from clk
`timescale 1ns/10ps

module baudTickGen (
	input logic clk,
	input logic rstN,
	uartLinkIf.phy link
);
	import debugPkg::*;

	logic [BAUD_CNT_W-1:0] count;

	// reload on zero, one tick per period
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0;
			link.sampleTick <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= BAUD_CNT_W'(BAUD_DIVISOR - 1);
			link.sampleTick <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			link.sampleTick <= 1'b0;
		end
	end

endmodule

// ==== design/debugCommandDecoder.sv ====
// debug command decoder for run, halt, single step and dump requests
`timescale 1ns/10ps

module debugCommandDecoder (
	input logic clk,
	input logic rstN,
	input logic [31:0] instructionLatch,
	uartLinkIf.core link,
	output logic dumpReq,
	output logic enable
);
	import debugPkg::*;

	logic stepMode;
	logic stepPulse;
	logic byteValid;

	// a badly framed byte never acts as a command
	assign byteValid = link.rxStrobe && !link.rxFrameError;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			stepMode <= 1'b0;
			stepPulse <= 1'b0;
			dumpReq <= 1'b0;
		end
		else
		begin
			stepPulse <= 1'b0;
			dumpReq <= 1'b0;
			if (byteValid)
			begin
				case (link.rxData)
					CMD_DUMP:
						dumpReq <= 1'b1;
					// one pipeline cycle, only while frozen
					CMD_STEP:
						stepPulse <= stepMode;
					CMD_HALT:
						stepMode <= 1'b1;
					CMD_RUN:
						stepMode <= 1'b0;
					default:
						stepPulse <= 1'b0;
				endcase
			end
		end
	end

	// halt word wins in the same cycle
	assign enable = (instructionLatch != HALT_WORD) && (!stepMode || stepPulse);

endmodule

// ==== design/debugPkg.sv ====
// debug unit package with command codes, frame layout, UART timing and snapshot types
package debugPkg;

	//////////////////////////////////////////////////
	// host command bytes
	//////////////////////////////////////////////////
	localparam logic [7:0] CMD_DUMP = 8'h64;
	localparam logic [7:0] CMD_STEP = 8'h73;
	localparam logic [7:0] CMD_HALT = 8'h68;
	localparam logic [7:0] CMD_RUN = 8'h72;

	// all-ones instruction stops the pipeline
	localparam logic [31:0] HALT_WORD = 32'hFFFF_FFFF;

	//////////////////////////////////////////////////
	// dump frame layout
	//////////////////////////////////////////////////
	localparam logic [7:0] FRAME_HEADER = 8'hA5;
	localparam int FRAME_BYTES = 136;
	localparam int CTRL_BYTES = 3;
	// everything after the header byte
	localparam int PAYLOAD_BITS = 8 * (FRAME_BYTES - 1);
	localparam int FRAME_IDX_W = $clog2(FRAME_BYTES + 1);

	//////////////////////////////////////////////////
	// UART timing, 2 for simulation, 163 on the board
	//////////////////////////////////////////////////
	localparam int BAUD_DIVISOR = 2;
	localparam int BAUD_CNT_W = $clog2(BAUD_DIVISOR + 1);
	localparam int OVERSAMPLE = 16;
	localparam int TICK_W = $clog2(OVERSAMPLE);
	localparam int DATA_BITS = 8;
	localparam int BIT_CNT_W = $clog2(DATA_BITS);

	// register 0 sits in the lowest word
	typedef logic [31:0][31:0] regFile_t;

	typedef struct packed {
		logic branchId;
		logic memReadId;
		logic memWriteId;
		logic aluSrcId;
		logic regWriteId;
		logic [1:0] regDstId;
		logic [1:0] memtoRegId;
		logic [1:0] aluOpId;
		logic memReadEx;
		logic memWriteEx;
		logic regWriteEx;
		logic [1:0] memtoRegEx;
		logic regWriteMem;
		logic [1:0] memtoRegMem;
	} ctrlSnapshot_t;

endpackage

// ==== design/debugUnit.sv ====
// serial debug unit top with UART blocks, command decoder and snapshot serializer
`timescale 1ns/10ps

module debugUnit (
	input logic clk,
	input logic rstN,
	input logic rx,
	input debugPkg::regFile_t regFile,
	input logic [31:0] instructionLatch,
	// ID stage control
	input logic branchId,
	input logic memReadId,
	input logic memWriteId,
	input logic aluSrcId,
	input logic regWriteId,
	input logic [1:0] regDstId,
	input logic [1:0] memtoRegId,
	input logic [1:0] aluOpId,
	// EX stage control
	input logic memReadEx,
	input logic memWriteEx,
	input logic regWriteEx,
	input logic [1:0] memtoRegEx,
	// MEM stage control
	input logic regWriteMem,
	input logic [1:0] memtoRegMem,
	output logic tx,
	output logic [7:0] rxData,
	output logic enable
);
	import debugPkg::*;

	uartLinkIf link ();

	ctrlSnapshot_t ctrl;
	logic dumpReq;

	assign ctrl = '{
		branchId: branchId,
		memReadId: memReadId,
		memWriteId: memWriteId,
		aluSrcId: aluSrcId,
		regWriteId: regWriteId,
		regDstId: regDstId,
		memtoRegId: memtoRegId,
		aluOpId: aluOpId,
		memReadEx: memReadEx,
		memWriteEx: memWriteEx,
		regWriteEx: regWriteEx,
		memtoRegEx: memtoRegEx,
		regWriteMem: regWriteMem,
		memtoRegMem: memtoRegMem
	};

	// last good byte from the host
	assign rxData = link.rxData;

	//////////////////////////////////////////////////
	// serial line side
	//////////////////////////////////////////////////
	baudTickGen i_baudTickGen (
		.clk(clk),
		.rstN(rstN),
		.link(link.phy)
	);

	uartReceiver i_uartReceiver (
		.clk(clk),
		.rstN(rstN),
		.rx(rx),
		.link(link.phy)
	);

	uartTransmitter i_uartTransmitter (
		.clk(clk),
		.rstN(rstN),
		.link(link.phy),
		.tx(tx)
	);

	//////////////////////////////////////////////////
	// debug core
	//////////////////////////////////////////////////
	debugCommandDecoder i_debugCommandDecoder (
		.clk(clk),
		.rstN(rstN),
		.instructionLatch(instructionLatch),
		.link(link.core),
		.dumpReq(dumpReq),
		.enable(enable)
	);

	snapshotSerializer i_snapshotSerializer (
		.clk(clk),
		.rstN(rstN),
		.dumpReq(dumpReq),
		.regFile(regFile),
		.instructionLatch(instructionLatch),
		.ctrl(ctrl),
		.link(link.core)
	);

endmodule

// ==== design/snapshotSerializer.sv ====
// snapshot serializer capturing pipeline state and feeding the dump frame to the transmitter
`timescale 1ns/10ps

module snapshotSerializer (
	input logic clk,
	input logic rstN,
	input logic dumpReq,
	input debugPkg::regFile_t regFile,
	input logic [31:0] instructionLatch,
	input debugPkg::ctrlSnapshot_t ctrl,
	uartLinkIf.core link
);
	import debugPkg::*;

	logic active;
	logic capture;
	logic [FRAME_IDX_W-1:0] byteIndex;
	logic [PAYLOAD_BITS-1:0] payload;
	logic [7:0] nextByte;

	// a request during a frame is dropped
	assign capture = dumpReq && !active;

	//////////////////////////////////////////////////
	// snapshot, registers then instruction then control
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			payload <= {
				{(8 * CTRL_BYTES - $bits(ctrlSnapshot_t)){1'b0}},
				ctrl,
				instructionLatch,
				regFile
			};
		end
	end

	// index 0 is the header, payload starts at index 1
	assign nextByte = payload[8 * (byteIndex - 1'b1) +: 8];

	//////////////////////////////////////////////////
	// byte sequencing
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			active <= 1'b0;
			byteIndex <= '0;
			link.txData <= 8'h00;
			link.txStart <= 1'b0;
		end
		else
		begin
			link.txStart <= 1'b0;
			if (capture)
			begin
				// transmitter is idle here, header goes out at once
				active <= 1'b1;
				byteIndex <= FRAME_IDX_W'(1);
				link.txData <= FRAME_HEADER;
				link.txStart <= 1'b1;
			end
			else if (active && !link.txBusy && !link.txStart)
			begin
				if (byteIndex == FRAME_IDX_W'(FRAME_BYTES))
				begin
					// last stop bit done
					active <= 1'b0;
				end
				else
				begin
					link.txData <= nextByte;
					link.txStart <= 1'b1;
					byteIndex <= byteIndex + 1'b1;
				end
			end
		end
	end

endmodule

// ==== design/uartLinkIf.sv ====
// UART link bundle between the serial line blocks and the debug core
`timescale 1ns/10ps

interface uartLinkIf;
	// 16x oversampling strobe
	logic sampleTick;

	// receive side
	logic [7:0] rxData;
	logic rxStrobe;
	logic rxFrameError;

	// transmit side
	logic [7:0] txData;
	logic txStart;
	logic txBusy;

	// line blocks: tick generator, receiver and transmitter
	modport phy (
		output sampleTick,
		output rxData,
		output rxStrobe,
		output rxFrameError,
		output txBusy,
		input txData,
		input txStart
	);

	// command decoder and frame serializer
	modport core (
		input rxData,
		input rxStrobe,
		input rxFrameError,
		input txBusy,
		output txData,
		output txStart
	);

endinterface

// ==== design/uartReceiver.sv ====
// oversampled 8N1 UART receiver with byte strobe and framing error flag
`timescale 1ns/10ps

module uartReceiver (
	input logic clk,
	input logic rstN,
	input logic rx,
	uartLinkIf.phy link
);
	import debugPkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rxState_t;

	rxState_t state;
	logic rxMeta;
	logic rxSync;
	logic [TICK_W-1:0] tickCount;
	logic [BIT_CNT_W-1:0] bitCount;
	logic [7:0] shiftReg;
	logic bitEnd;

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
		end
	end

	// middle of a data or stop bit
	assign bitEnd = link.sampleTick && (tickCount == TICK_W'(OVERSAMPLE - 1));

	// lsb arrives first
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && bitEnd)
			shiftReg <= {rxSync, shiftReg[7:1]};
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= RX_IDLE;
			tickCount <= '0;
			bitCount <= '0;
			link.rxData <= 8'h00;
			link.rxStrobe <= 1'b0;
			link.rxFrameError <= 1'b0;
		end
		else
		begin
			link.rxStrobe <= 1'b0;
			link.rxFrameError <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					tickCount <= '0;
					if (!rxSync)
						state <= RX_START;
				end
				RX_START:
				begin
					if (link.sampleTick)
					begin
						// half a bit in, recheck the start level
						if (tickCount == TICK_W'(OVERSAMPLE / 2 - 1))
						begin
							tickCount <= '0;
							bitCount <= '0;
							state <= rxSync ? RX_IDLE : RX_DATA;
						end
						else
							tickCount <= tickCount + 1'b1;
					end
				end
				RX_DATA:
				begin
					if (bitEnd)
					begin
						tickCount <= '0;
						bitCount <= bitCount + 1'b1;
						if (bitCount == BIT_CNT_W'(DATA_BITS - 1))
							state <= RX_STOP;
					end
					else if (link.sampleTick)
						tickCount <= tickCount + 1'b1;
				end
				RX_STOP:
				begin
					if (bitEnd)
					begin
						state <= RX_IDLE;
						if (rxSync)
						begin
							link.rxData <= shiftReg;
							link.rxStrobe <= 1'b1;
						end
						else
							link.rxFrameError <= 1'b1;
					end
					else if (link.sampleTick)
						tickCount <= tickCount + 1'b1;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

endmodule

// ==== design/uartTransmitter.sv ====
// 8N1 UART transmitter started by a single-cycle strobe
`timescale 1ns/10ps

module uartTransmitter (
	input logic clk,
	input logic rstN,
	uartLinkIf.phy link,
	output logic tx
);
	import debugPkg::*;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_ALIGN,
		TX_START,
		TX_DATA,
		TX_STOP
	} txState_t;

	txState_t state;
	logic [TICK_W-1:0] tickCount;
	logic [BIT_CNT_W-1:0] bitCount;
	logic [7:0] shiftReg;
	logic bitEnd;

	assign bitEnd = link.sampleTick && (tickCount == TICK_W'(OVERSAMPLE - 1));

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= TX_IDLE;
			tickCount <= '0;
			bitCount <= '0;
			shiftReg <= 8'h00;
			tx <= 1'b1;
			link.txBusy <= 1'b0;
		end
		else
		begin
			if (link.sampleTick && !bitEnd)
				tickCount <= tickCount + 1'b1;
			case (state)
				TX_IDLE:
				begin
					if (link.txStart)
					begin
						shiftReg <= link.txData;
						link.txBusy <= 1'b1;
						state <= TX_ALIGN;
					end
				end
				// start bit lines up with the tick grid
				TX_ALIGN:
				begin
					if (link.sampleTick)
					begin
						tx <= 1'b0;
						tickCount <= '0;
						state <= TX_START;
					end
				end
				TX_START:
				begin
					if (bitEnd)
					begin
						tx <= shiftReg[0];
						tickCount <= '0;
						bitCount <= '0;
						state <= TX_DATA;
					end
				end
				TX_DATA:
				begin
					if (bitEnd)
					begin
						tickCount <= '0;
						if (bitCount == BIT_CNT_W'(DATA_BITS - 1))
						begin
							tx <= 1'b1;
							state <= TX_STOP;
						end
						else
						begin
							tx <= shiftReg[1];
							shiftReg <= shiftReg >> 1;
							bitCount <= bitCount + 1'b1;
						end
					end
				end
				TX_STOP:
				begin
					if (bitEnd)
					begin
						tickCount <= '0;
						link.txBusy <= 1'b0;
						state <= TX_IDLE;
					end
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

endmodule

// ==== flist.f ====
+incdir+include
design/debugPkg.sv
design/uartLinkIf.sv
design/baudTickGen.sv
design/uartReceiver.sv
design/debugCommandDecoder.sv
design/snapshotSerializer.sv
design/uartTransmitter.sv
design/debugUnit.sv
verification/debugUnitTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module debugUnitTb -f flist.f -o debugUnitSim
./obj_dir/debugUnitSim > sim.log 2>&1
cat sim.log

if grep -qx "No errors" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== include/tbUartTasks.svh ====
// UART host line tasks, bit-banged byte send on rx and timed byte capture from tx
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// one level on rx for a number of clock cycles
task driveLevel(input logic level, input int cycles);
	rx <= level;
	repeat (cycles) @(posedge clk);
endtask

// 8N1 character, goodStop low gives a framing error
task sendByte(input logic [7:0] data, input logic goodStop);
	int i;
	@(posedge clk);
	driveLevel(1'b0, BIT_CYCLES);
	for (i = 0; i < DATA_BITS; i++)
		driveLevel(data[i], BIT_CYCLES);
	if (goodStop)
		driveLevel(1'b1, BIT_CYCLES);
	else
	begin
		// short low stop, line is high again before the receiver rearms
		driveLevel(1'b0, BIT_CYCLES * 3 / 4);
		driveLevel(1'b1, BIT_CYCLES / 4);
	end
	// idle gap between characters
	driveLevel(1'b1, BIT_CYCLES);
endtask

task waitStartBit(output logic found);
	int waited;
	found = 1'b0;
	for (waited = 0; waited < START_TIMEOUT && !found; waited++)
	begin
		@(negedge clk);
		if (tx === 1'b0)
			found = 1'b1;
	end
	if (!found)
		reportProblem("timeout, no start bit seen on tx");
endtask

// called right after the falling edge of a start bit, samples mid bit
task readByte(output logic [7:0] data);
	int i;
	repeat (BIT_CYCLES / 2) @(negedge clk);
	if (tx !== 1'b0)
		reportProblem("start bit on tx ended early");
	for (i = 0; i < DATA_BITS; i++)
	begin
		repeat (BIT_CYCLES) @(negedge clk);
		data[i] = tx;
	end
	repeat (BIT_CYCLES) @(negedge clk);
	if (tx !== 1'b1)
		reportProblem("stop bit on tx is low");
endtask

task receiveByte(output logic [7:0] data, output logic ok);
	data = 8'h00;
	waitStartBit(ok);
	if (ok)
		readByte(data);
endtask

`endif

// ==== verification/debugUnitTb.sv ====
// testbench for the serial debug unit with a UART host model and dump frame checker
`timescale 1ns/10ps

module debugUnitTb;
	import debugPkg::*;

	localparam int BIT_CYCLES = BAUD_DIVISOR * OVERSAMPLE;
	localparam int CHAR_CYCLES = 12 * BIT_CYCLES;
	localparam int START_TIMEOUT = 20 * BIT_CYCLES;

	logic clk;
	logic rstN;
	logic rx;
	regFile_t regFile;
	logic [31:0] instr;
	// control bits in ctrlSnapshot_t order with branchId on top
	logic [18:0] ctrlBits;
	logic tx;
	logic [7:0] rxData;
	logic enable;

	// reference model state
	logic modelStepMode;
	logic [7:0] expectedRxData;
	logic [31:0] heldRegs [32];
	logic [31:0] heldInstr;
	logic [18:0] heldCtrl;
	logic [7:0] expFrame [FRAME_BYTES];

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int errorsAtStart = 0;
	int enableHighCycles = 0;
	int k;
	int steps;
	int highBefore;
	logic [7:0] cmd;

	debugUnit i_dut (
		.clk(clk),
		.rstN(rstN),
		.rx(rx),
		.regFile(regFile),
		.instructionLatch(instr),
		.branchId(ctrlBits[18]),
		.memReadId(ctrlBits[17]),
		.memWriteId(ctrlBits[16]),
		.aluSrcId(ctrlBits[15]),
		.regWriteId(ctrlBits[14]),
		.regDstId(ctrlBits[13:12]),
		.memtoRegId(ctrlBits[11:10]),
		.aluOpId(ctrlBits[9:8]),
		.memReadEx(ctrlBits[7]),
		.memWriteEx(ctrlBits[6]),
		.regWriteEx(ctrlBits[5]),
		.memtoRegEx(ctrlBits[4:3]),
		.regWriteMem(ctrlBits[2]),
		.memtoRegMem(ctrlBits[1:0]),
		.tx(tx),
		.rxData(rxData),
		.enable(enable)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// pipeline cycles granted during the step test
	always @(negedge clk)
	begin
		if (enable === 1'b1)
			enableHighCycles = enableHighCycles + 1;
	end

	//////////////////////////////////////////////////
	// checking helpers
	//////////////////////////////////////////////////
	task checkValue(input string name, input logic [31:0] actual, input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Mismatch at %0d ns: %s is %0h, expected %0h",
				$time, name, actual, expected);
		end
	endtask

	task reportProblem(input string msg);
		errorCount++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task beginTest;
		errorsAtStart = errorCount;
		testCount++;
	endtask

	task endTest(input string name);
		$display("test %0d %s: %0d errors", testCount, name, errorCount - errorsAtStart);
	endtask

	`include "tbUartTasks.svh"

	function automatic logic [31:0] nonHaltWord();
		logic [31:0] v;
		v = $urandom;
		if (v == HALT_WORD)
			v = 32'h0000_0000;
		return v;
	endfunction

	// run mode follows the halt word and step mode is low between pulses
	function automatic logic expectedEnable();
		return (instr != HALT_WORD) && !modelStepMode;
	endfunction

	task randomizeInputs;
		regFile_t packedRegs;
		int r;
		for (r = 0; r < 32; r++)
		begin
			heldRegs[r] = $urandom;
			packedRegs[r] = heldRegs[r];
		end
		heldInstr = $urandom;
		heldCtrl = 19'($urandom);
		regFile <= packedRegs;
		instr <= heldInstr;
		ctrlBits <= heldCtrl;
	endtask

	// frame bytes in wire order with every field lsb first
	task buildFrame;
		int r;
		int b;
		logic [23:0] ctrlWord;
		expFrame[0] = FRAME_HEADER;
		for (r = 0; r < 32; r++)
			for (b = 0; b < 4; b++)
				expFrame[1 + 4 * r + b] = heldRegs[r][8 * b +: 8];
		for (b = 0; b < 4; b++)
			expFrame[129 + b] = heldInstr[8 * b +: 8];
		ctrlWord = {5'b00000, heldCtrl};
		for (b = 0; b < 3; b++)
			expFrame[133 + b] = ctrlWord[8 * b +: 8];
	endtask

	task sendCommand(input logic [7:0] data, input logic goodStop);
		sendByte(data, goodStop);
		if (goodStop)
		begin
			expectedRxData = data;
			if (data == CMD_HALT)
				modelStepMode = 1'b1;
			else if (data == CMD_RUN)
				modelStepMode = 1'b0;
		end
		@(negedge clk);
		checkValue("rxData", rxData, expectedRxData);
		checkValue("enable", enable, expectedEnable());
	endtask

	// tx must stay idle and enable constant over the window
	task checkQuiet(input int cycles, input logic expEnable);
		int n;
		int txLow;
		int enableWrong;
		txLow = 0;
		enableWrong = 0;
		for (n = 0; n < cycles; n++)
		begin
			@(negedge clk);
			if (tx !== 1'b1)
				txLow++;
			if (enable !== expEnable)
				enableWrong++;
		end
		checkValue("tx low cycles", txLow, 0);
		checkValue("enable wrong cycles", enableWrong, 0);
	endtask

	task receiveFrame;
		logic [7:0] data;
		logic ok;
		int idx;
		waitStartBit(ok);
		if (ok)
		begin
			// pipeline moves on once the first start bit is out
			@(posedge clk);
			randomizeInputs();
			readByte(data);
			checkValue("tx byte 0", data, expFrame[0]);
			for (idx = 1; idx < FRAME_BYTES && ok; idx++)
			begin
				receiveByte(data, ok);
				if (ok)
					checkValue($sformatf("tx byte %0d", idx), data, expFrame[idx]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial
	begin
		void'($urandom(43));
		rstN = 1'b0;
		rx = 1'b1;
		regFile = '0;
		instr = nonHaltWord();
		ctrlBits = '0;
		modelStepMode = 1'b0;
		expectedRxData = 8'h00;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		beginTest();
		@(negedge clk);
		checkValue("rxData", rxData, 8'h00);
		checkValue("enable", enable, 1'b1);
		checkQuiet(FRAME_BYTES * 10 * BIT_CYCLES, 1'b1);
		endTest("after reset");

		// roughly one halt word in four
		beginTest();
		for (k = 0; k < 300; k++)
		begin
			@(posedge clk);
			instr <= ($urandom_range(0, 3) == 0) ? HALT_WORD : $urandom;
			@(negedge clk);
			checkValue("enable", enable, expectedEnable());
		end
		@(posedge clk);
		instr <= nonHaltWord();
		endTest("halt word");

		beginTest();
		sendCommand(CMD_HALT, 1'b1);
		@(posedge clk);
		highBefore = enableHighCycles;
		steps = $urandom_range(2, 5);
		for (k = 0; k < steps; k++)
			sendCommand(CMD_STEP, 1'b1);
		@(posedge clk);
		checkValue("enable high cycles", enableHighCycles - highBefore, steps);
		sendCommand(CMD_RUN, 1'b1);
		endTest("stepping");

		// second dump request lands mid frame and must be dropped
		beginTest();
		@(posedge clk);
		randomizeInputs();
		buildFrame();
		fork
			begin
				sendCommand(CMD_DUMP, 1'b1);
				repeat (20 * BIT_CYCLES) @(posedge clk);
				sendCommand(CMD_DUMP, 1'b1);
			end
			receiveFrame();
		join
		checkQuiet(2 * CHAR_CYCLES, expectedEnable());
		endTest("dump");

		beginTest();
		@(posedge clk);
		instr <= nonHaltWord();
		for (k = 0; k < 4; k++)
		begin
			cmd = 8'($urandom);
			while (cmd == CMD_DUMP || cmd == CMD_STEP || cmd == CMD_HALT || cmd == CMD_RUN)
				cmd = cmd + 8'd1;
			fork
				sendCommand(cmd, 1'b1);
				checkQuiet(CHAR_CYCLES, 1'b1);
			join
		end
		endTest("unknown commands");

		beginTest();
		fork
			sendCommand(CMD_DUMP, 1'b0);
			checkQuiet(CHAR_CYCLES, 1'b1);
		join
		fork
			sendCommand(CMD_HALT, 1'b0);
			checkQuiet(CHAR_CYCLES, 1'b1);
		join
		endTest("framing error");

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
